/* filelist.f */
+incdir+logic
logic/hdmi_tx_pkg.sv
logic/hdmi_tx_regs.sv
logic/frame_fetch.sv
logic/video_timing.sv
logic/pixel_out.sv
logic/hdmi_tx_ctrl.sv
sim/sys_mem_model.sv
sim/hdmi_tx_tb.sv

/* Makefile */
# Verilator build and run of the HDMI TX testbench
TOP := hdmi_tx_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* sim/hdmi_tx_tb.sv */
////////////////////////////////////////
// Testbench top for the HDMI TX controller
// Runs a table of register steps
// Scoreboards pins against the frame pattern
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module hdmi_tx_tb;

  localparam int H_TOTAL   = `HTX_H_ACTIVE + `HTX_H_FP + `HTX_H_SYNC + `HTX_H_BP;
  localparam int V_TOTAL   = `HTX_V_ACTIVE + `HTX_V_FP + `HTX_V_SYNC + `HTX_V_BP;
  localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
  // Three frames of raster plus register traffic
  localparam int WDOG_CYC  = 3 * FRAME_CYC + 500;
  localparam int NUM_STEPS = 22;
  localparam logic [31:0] FULL_OCC = `HTX_BUF_DEPTH;

  typedef enum logic [2:0] {
    STEP_WR,
    STEP_RD,
    STEP_POLL,
    STEP_IDLE,
    STEP_FRAMES
  } step_kind_e;

  // One table row, count is cycles or frames
  typedef struct packed {
    step_kind_e                   kind;
    logic [`HTX_LB_ADDR_W-1:0]    addr;
    logic [`HTX_LB_DATA_W-1:0]    data;
    logic [15:0]                  count;
  } step_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  hdmi_tx_pkg::lb_req_t      lb_req;
  hdmi_tx_pkg::lb_rsp_t      lb_rsp;
  hdmi_tx_pkg::mem_req_t     mem_req;
  hdmi_tx_pkg::mem_rsp_t     mem_rsp;
  hdmi_tx_pkg::hdmi_out_t    hdmi;
  step_t                     steps [NUM_STEPS];
  // High while the buffer is expected to stream real frame data
  logic                      fetch_on;
  int                        pix_cnt;
  int                        zero_cnt;
  int                        frame_cnt;
  int                        de_run;
  int                        hs_run;
  int                        vs_run;
  int                        frame_de;
  logic                      prev_de;
  logic                      prev_hs;
  logic                      prev_vs;
  logic                      prev_wait;
  hdmi_tx_pkg::mem_req_t     prev_req;
  logic [`HTX_PIX_W-1:0]     exp_pix;

  always #5 clk = ~clk;

  hdmi_tx_ctrl hdmi_tx_ctrl_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .lb_req  (lb_req),
    .lb_rsp  (lb_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .hdmi    (hdmi)
  );

  sys_mem_model #(.SEED(32'haee6_0c08)) sys_mem_model_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  task automatic fail_run(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // Pixel stored at a frame-buffer word address
  function automatic logic [`HTX_PIX_W-1:0] pattern_of(input int addr);
    return `HTX_PIX_W'(addr * 3 + 5);
  endfunction

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    if (addr == `HTX_CFG_ADDR && !data[0])
      fetch_on = 1'b0;
    lb_req.wr_en   = 1'b1;
    lb_req.addr    = addr;
    lb_req.wr_data = data;
    @(negedge clk);
    assert (!lb_rsp.wr_valid) else fail_run("write valid ahead of its strobe");
    @(posedge clk);
    #1;
    lb_req.wr_en = 1'b0;
    // Register has taken the value by now
    if (addr == `HTX_CFG_ADDR && data[0])
      fetch_on = 1'b1;
    @(negedge clk);
    assert (lb_rsp.wr_valid) else fail_run("write valid missing one cycle after strobe");
    @(negedge clk);
    assert (!lb_rsp.wr_valid) else fail_run("write valid longer than one cycle");
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    lb_req.rd_en = 1'b1;
    lb_req.addr  = addr;
    @(negedge clk);
    assert (!lb_rsp.rd_valid) else fail_run("read valid ahead of its strobe");
    @(posedge clk);
    #1;
    lb_req.rd_en = 1'b0;
    @(negedge clk);
    assert (lb_rsp.rd_valid) else fail_run("read valid missing one cycle after strobe");
    data = lb_rsp.rd_data;
    @(negedge clk);
    assert (!lb_rsp.rd_valid) else fail_run("read valid longer than one cycle");
  endtask

  task automatic run_step(input step_t st);
    logic [31:0] rd;
    int          target;
    case (st.kind)
      STEP_WR: bus_write(st.addr, st.data);
      STEP_RD:
      begin
        bus_read(st.addr, rd);
        assert (rd == st.data)
          else fail_run($sformatf("reg 0x%0h read 0x%0h, expected 0x%0h", st.addr, rd, st.data));
      end
      STEP_POLL:
      begin
        // Fill time depends on memory wait, watchdog bounds it
        bus_read(st.addr, rd);
        while (rd != st.data)
          bus_read(st.addr, rd);
      end
      STEP_IDLE: repeat (st.count) @(posedge clk);
      STEP_FRAMES:
      begin
        target = frame_cnt + int'(st.count);
        while (frame_cnt < target)
          @(posedge clk);
      end
      default: fail_run("unknown table step kind");
    endcase
  endtask

  // Pin and memory monitor, sampled mid-cycle
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      prev_de   = 1'b0;
      prev_hs   = 1'b1;
      prev_vs   = 1'b1;
      prev_wait = 1'b0;
      prev_req  = '0;
      pix_cnt   = 0;
      zero_cnt  = 0;
      frame_cnt = 0;
      de_run    = 0;
      hs_run    = 0;
      vs_run    = 0;
      frame_de  = 0;
    end
    else
    begin
      // Stalled request must stay put
      if (fetch_on && prev_req.rd_en && prev_wait)
        assert (mem_req == prev_req)
          else fail_run($sformatf("request at 0x%0h moved during wait", prev_req.addr));
      prev_req  = mem_req;
      prev_wait = mem_rsp.wait_lvl;
      if (hdmi.de)
      begin
        de_run++;
        frame_de++;
        if (fetch_on)
        begin
          exp_pix = pattern_of(`HTX_FB_BASE + pix_cnt % `HTX_FB_WORDS);
          assert (hdmi.d == exp_pix)
            else fail_run($sformatf("pixel %0d is 0x%06h, expected 0x%06h",
                                    pix_cnt, hdmi.d, exp_pix));
          pix_cnt++;
        end
        else
        begin
          // Starved buffer gives black
          assert (hdmi.d == '0)
            else fail_run($sformatf("starved pixel is 0x%06h, expected 0", hdmi.d));
          zero_cnt++;
        end
      end
      if (prev_de && !hdmi.de)
      begin
        assert (de_run == `HTX_H_ACTIVE)
          else fail_run($sformatf("line had %0d de cycles", de_run));
        de_run = 0;
      end
      if (!hdmi.hs)
        hs_run++;
      if (!prev_hs && hdmi.hs)
      begin
        assert (hs_run == `HTX_H_SYNC)
          else fail_run($sformatf("hs low for %0d cycles", hs_run));
        hs_run = 0;
      end
      if (!hdmi.vs)
        vs_run++;
      // End of vertical sync closes a frame
      if (!prev_vs && hdmi.vs)
      begin
        assert (vs_run == `HTX_V_SYNC * H_TOTAL)
          else fail_run($sformatf("vs low for %0d cycles", vs_run));
        assert (frame_de == `HTX_FB_WORDS)
          else fail_run($sformatf("frame had %0d de cycles", frame_de));
        vs_run   = 0;
        frame_de = 0;
        frame_cnt++;
      end
      prev_de = hdmi.de;
      prev_hs = hdmi.hs;
      prev_vs = hdmi.vs;
    end
  end

  initial
  begin
    #(WDOG_CYC * 10);
    $display("Run timed out after %0d cycles without finishing", WDOG_CYC);
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial
  begin
    lb_req   = '0;
    rst_n    = 1'b0;
    fetch_on = 1'b0;
    steps = '{
      // Reset values and an unmapped address
      '{STEP_RD,     `HTX_CFG_ADDR,  32'h0,           16'd0},
      '{STEP_RD,     `HTX_STAT_ADDR, 32'h0,           16'd0},
      '{STEP_RD,     `HTX_OCC_ADDR,  32'h0,           16'd0},
      '{STEP_RD,     8'h3c,          `HTX_DEFAULT_RD, 16'd0},
      // Fill only
      '{STEP_WR,     `HTX_CFG_ADDR,  32'h1,           16'd0},
      '{STEP_RD,     `HTX_CFG_ADDR,  32'h1,           16'd0},
      '{STEP_POLL,   `HTX_OCC_ADDR,  FULL_OCC,        16'd0},
      '{STEP_IDLE,   8'h00,          32'h0,           16'd20},
      '{STEP_RD,     `HTX_OCC_ADDR,  FULL_OCC,        16'd0},
      // Two frames of real data, stopped at a frame edge
      '{STEP_WR,     `HTX_CFG_ADDR,  32'h3,           16'd0},
      '{STEP_FRAMES, 8'h00,          32'h0,           16'd2},
      '{STEP_WR,     `HTX_CFG_ADDR,  32'h1,           16'd0},
      '{STEP_IDLE,   8'h00,          32'h0,           16'd4},
      '{STEP_WR,     `HTX_CFG_ADDR,  32'h0,           16'd0},
      '{STEP_RD,     `HTX_STAT_ADDR, 32'h0,           16'd0},
      // Raster with nothing fetched
      '{STEP_WR,     `HTX_CFG_ADDR,  32'h2,           16'd0},
      '{STEP_FRAMES, 8'h00,          32'h0,           16'd1},
      '{STEP_WR,     `HTX_CFG_ADDR,  32'h0,           16'd0},
      '{STEP_RD,     `HTX_STAT_ADDR, 32'h1,           16'd0},
      '{STEP_WR,     `HTX_STAT_ADDR, 32'h1,           16'd0},
      '{STEP_RD,     `HTX_STAT_ADDR, 32'h0,           16'd0},
      '{STEP_RD,     `HTX_CFG_ADDR,  32'h0,           16'd0}
    };
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!mem_req.rd_en && !lb_rsp.wr_valid && !lb_rsp.rd_valid &&
            !hdmi.de && hdmi.hs && hdmi.vs)
      else fail_run("outputs not idle after reset");
    for (int i = 0; i < NUM_STEPS; i++)
      run_step(steps[i]);
    // Every expected pixel must have been seen
    if (pix_cnt == 2 * `HTX_FB_WORDS && zero_cnt == `HTX_FB_WORDS)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      fail_run($sformatf("saw %0d data and %0d starved pixels", pix_cnt, zero_cnt));
    end
  end

endmodule

/* sim/sys_mem_model.sv */
////////////////////////////////////////
// Behavioural system memory, read only
// Random wait level, two-cycle read latency
// Word value follows from its address
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module sys_mem_model #(
  parameter logic [31:0] SEED = 32'haee6_0c08
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  hdmi_tx_pkg::mem_req_t    mem_req,
  output hdmi_tx_pkg::mem_rsp_t    mem_rsp
);

  integer                        seed;
  logic                          wait_q;
  logic                          accept;
  logic                          v1;
  logic                          v2;
  logic [`HTX_MEM_DATA_W-1:0]    d1;
  logic [`HTX_MEM_DATA_W-1:0]    d2;

  // Pixel bits are address times 3 plus 5, upper bits carry the rest
  function automatic logic [`HTX_MEM_DATA_W-1:0] word_at(input logic [`HTX_MEM_ADDR_W-1:0] a);
    return `HTX_MEM_DATA_W'(a) * 32'd3 + 32'd5;
  endfunction

  initial seed = SEED;

  // Taken on a cycle with wait low
  assign accept = mem_req.rd_en && !wait_q;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wait_q <= 1'b0;
      v1     <= 1'b0;
      v2     <= 1'b0;
      d1     <= '0;
      d2     <= '0;
    end
    else
    begin
      // Roughly one cycle in four stalls
      wait_q <= (($random(seed) & 3) == 0);
      // Two-stage return pipe
      v1     <= accept;
      d1     <= word_at(mem_req.addr);
      v2     <= v1;
      d2     <= d1;
    end
  end

  assign mem_rsp.wait_lvl = wait_q;
  assign mem_rsp.rd_valid = v2;
  assign mem_rsp.rd_data  = d2;

endmodule

/* logic/hdmi_tx_ctrl.sv */
////////////////////////////////////////
// HDMI transmitter controller top
// Registers, fetcher, timing and pin stage
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module hdmi_tx_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  hdmi_tx_pkg::lb_req_t     lb_req,
  output hdmi_tx_pkg::lb_rsp_t     lb_rsp,
  output hdmi_tx_pkg::mem_req_t    mem_req,
  input  hdmi_tx_pkg::mem_rsp_t    mem_rsp,
  output hdmi_tx_pkg::hdmi_out_t   hdmi
);

  hdmi_tx_pkg::ctrl_t        ctrl;
  hdmi_tx_pkg::raster_t      raster;
  logic [`HTX_PIX_W-1:0]     head;
  logic                      empty;
  logic                      pop;
  logic                      undrflw_evt;
  logic [`HTX_OCC_W-1:0]     occ;

  // Host registers
  hdmi_tx_regs hdmi_tx_regs_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .lb_req      (lb_req),
    .lb_rsp      (lb_rsp),
    .occ         (occ),
    .undrflw_evt (undrflw_evt),
    .ctrl        (ctrl)
  );

  // Memory reads into the line buffer
  frame_fetch frame_fetch_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .fetch_en (ctrl.fetch_en),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .occ      (occ)
  );

  // Raster counters
  video_timing video_timing_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .drvr_en (ctrl.drvr_en),
    .raster  (raster)
  );

  // Pin stage
  pixel_out pixel_out_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .raster      (raster),
    .head        (head),
    .empty       (empty),
    .pop         (pop),
    .undrflw_evt (undrflw_evt),
    .hdmi        (hdmi)
  );

endmodule

/* logic/pixel_out.sv */
////////////////////////////////////////
// Pixel output stage
// Pops the line buffer on active positions
// Pins registered one cycle behind the raster
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module pixel_out (
  input  logic                     clk,
  input  logic                     rst_n,
  input  hdmi_tx_pkg::raster_t     raster,
  input  logic [`HTX_PIX_W-1:0]    head,
  input  logic                     empty,
  output logic                     pop,
  output logic                     undrflw_evt,
  output hdmi_tx_pkg::hdmi_out_t   hdmi
);

  logic [`HTX_PIX_W-1:0]   d_q;
  logic                    de_q;
  logic                    hs_q;
  logic                    vs_q;
  logic                    undrflw_q;
  logic                    starved;

  // Active position with nothing stored
  assign starved = raster.active && empty;
  assign pop     = raster.active && !empty;

  // Control pins, idle is de low and both syncs high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      de_q      <= 1'b0;
      hs_q      <= 1'b1;
      vs_q      <= 1'b1;
      undrflw_q <= 1'b0;
    end
    else
    begin
      de_q      <= raster.active;
      hs_q      <= ~raster.hsync;
      vs_q      <= ~raster.vsync;
      undrflw_q <= starved;
    end
  end

  // Pixel data, zero outside active and when starved
  always_ff @(posedge clk)
  begin
    d_q <= pop ? head : '0;
  end

  assign hdmi.d      = d_q;
  assign hdmi.de     = de_q;
  assign hdmi.hs     = hs_q;
  assign hdmi.vs     = vs_q;
  assign undrflw_evt = undrflw_q;

endmodule

/* logic/video_timing.sv */
////////////////////////////////////////
// Video timing generator
// Pixel and line counters with region flags
// Starts at position zero after drvr_en rises
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module video_timing (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   drvr_en,
  output hdmi_tx_pkg::raster_t   raster
);

  // Region boundaries, order is active, porch, sync, porch
  localparam int H_SYNC_ST  = `HTX_H_ACTIVE + `HTX_H_FP;
  localparam int H_SYNC_END = H_SYNC_ST + `HTX_H_SYNC;
  localparam int H_TOTAL    = H_SYNC_END + `HTX_H_BP;
  localparam int V_SYNC_ST  = `HTX_V_ACTIVE + `HTX_V_FP;
  localparam int V_SYNC_END = V_SYNC_ST + `HTX_V_SYNC;
  localparam int V_TOTAL    = V_SYNC_END + `HTX_V_BP;
  localparam int H_CNT_W    = $clog2(H_TOTAL);
  localparam int V_CNT_W    = $clog2(V_TOTAL);

  logic                  run;
  logic [H_CNT_W-1:0]    h_cnt;
  logic [V_CNT_W-1:0]    v_cnt;
  logic                  h_last;
  logic                  v_last;
  logic                  h_act;
  logic                  v_act;

  assign h_last = (h_cnt == H_TOTAL - 1);
  assign v_last = (v_cnt == V_TOTAL - 1);

  // Counters
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run   <= 1'b0;
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else
    begin
      // One cycle of delay gives the counter start
      run <= drvr_en;
      if (!drvr_en)
      begin
        h_cnt <= '0;
        v_cnt <= '0;
      end
      else if (run)
      begin
        if (h_last)
        begin
          h_cnt <= '0;
          // Next line, or back to the top of the frame
          v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
        else
        begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  assign h_act = (h_cnt < `HTX_H_ACTIVE);
  assign v_act = (v_cnt < `HTX_V_ACTIVE);

  // Flags stay low until counting has begun
  assign raster.active = run && h_act && v_act;
  assign raster.hsync  = run && (h_cnt >= H_SYNC_ST) && (h_cnt < H_SYNC_END);
  assign raster.vsync  = run && (v_cnt >= V_SYNC_ST) && (v_cnt < V_SYNC_END);

endmodule

/* logic/frame_fetch.sv */
////////////////////////////////////////
// Frame fetcher and line buffer
// Streams frame words from memory into a FIFO
// Credit keeps in-flight plus stored within depth
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module frame_fetch (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_en,
  output hdmi_tx_pkg::mem_req_t    mem_req,
  input  hdmi_tx_pkg::mem_rsp_t    mem_rsp,
  input  logic                     pop,
  output logic [`HTX_PIX_W-1:0]    head,
  output logic                     empty,
  output logic [`HTX_OCC_W-1:0]    occ
);

  localparam int PTR_W = $clog2(`HTX_BUF_DEPTH);
  localparam logic [`HTX_MEM_ADDR_W-1:0] FB_FIRST = `HTX_FB_BASE;
  localparam logic [`HTX_MEM_ADDR_W-1:0] FB_LAST  = `HTX_FB_BASE + `HTX_FB_WORDS - 1;

  logic                          rd_en;
  logic [`HTX_MEM_ADDR_W-1:0]    rd_addr;
  logic [`HTX_OCC_W-1:0]         cred;
  logic [`HTX_OCC_W-1:0]         pend;
  logic [`HTX_OCC_W-1:0]         pend_nxt;
  logic [`HTX_OCC_W-1:0]         occ_cnt;
  logic                          drain;
  logic                          accept;
  logic                          slot_free;
  logic                          issue;
  logic                          push;
  logic                          pop_ok;
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  logic [`HTX_PIX_W-1:0]         buf_mem [`HTX_BUF_DEPTH];

  // Request taken on a cycle with wait low
  assign accept    = rd_en && !mem_rsp.wait_lvl;
  // Request slot can take a new address
  assign slot_free = !rd_en || accept;
  // Credit counts the held request, reads in flight and stored words
  assign issue     = fetch_en && !drain && slot_free && (cred < `HTX_BUF_DEPTH);
  // Returns for reads issued before a flush are dropped
  assign push      = mem_rsp.rd_valid && fetch_en && !drain;
  assign pop_ok    = pop && !empty;
  assign pend_nxt  = pend + `HTX_OCC_W'(accept) - `HTX_OCC_W'(mem_rsp.rd_valid);

  // Request register, held steady through wait
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_en   <= 1'b0;
      rd_addr <= FB_FIRST;
    end
    else if (!fetch_en)
    begin
      rd_en   <= 1'b0;
      rd_addr <= FB_FIRST;
    end
    else
    begin
      // Step through the frame, wrap at the last word
      if (accept)
        rd_addr <= (rd_addr == FB_LAST) ? FB_FIRST : rd_addr + 1'b1;
      if (slot_free)
        rd_en <= issue;
    end
  end

  // Credit and outstanding read tracking
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cred  <= '0;
      pend  <= '0;
      drain <= 1'b0;
    end
    else
    begin
      pend <= pend_nxt;
      if (!fetch_en)
        cred <= '0;
      else
        cred <= cred + `HTX_OCC_W'(issue) - `HTX_OCC_W'(pop_ok);
      // Stale reads must come back before fetching restarts
      if (!fetch_en)
        drain <= (pend_nxt != '0);
      else if (pend_nxt == '0)
        drain <= 1'b0;
    end
  end

  // Line buffer storage, low pixel bits only
  always_ff @(posedge clk)
  begin
    if (push)
      buf_mem[wr_ptr] <= mem_rsp.rd_data[`HTX_PIX_W-1:0];
  end

  // FIFO pointers and fill count
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      occ_cnt <= '0;
    end
    else if (!fetch_en)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      occ_cnt <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      occ_cnt <= occ_cnt + `HTX_OCC_W'(push) - `HTX_OCC_W'(pop_ok);
    end
  end

  assign mem_req.rd_en = rd_en;
  assign mem_req.addr  = rd_addr;

  // Head word shown ahead of the pop
  assign head  = buf_mem[rd_ptr];
  assign empty = (occ_cnt == '0);
  assign occ   = occ_cnt;

endmodule

/* logic/hdmi_tx_regs.sv */
////////////////////////////////////////
// Local bus register block
// Config, sticky status and buffer occupancy
// Writes land one edge after the strobe
// Reads return one cycle after the strobe
////////////////////////////////////////

`timescale 1ns/100ps

`include "hdmi_tx_macros.svh"

module hdmi_tx_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  hdmi_tx_pkg::lb_req_t   lb_req,
  output hdmi_tx_pkg::lb_rsp_t   lb_rsp,
  input  logic [`HTX_OCC_W-1:0]  occ,
  input  logic                   undrflw_evt,
  output hdmi_tx_pkg::ctrl_t     ctrl
);

  logic                        fetch_en;
  logic                        drvr_en;
  logic                        undrflw;
  logic                        wr_valid;
  logic                        rd_valid;
  logic [`HTX_LB_DATA_W-1:0]   rd_data;
  logic                        cfg_wr;
  logic                        stat_clr;

  // Address decode for writes
  assign cfg_wr   = lb_req.wr_en && (lb_req.addr == `HTX_CFG_ADDR);
  // Write-1-to-clear on status bit 0
  assign stat_clr = lb_req.wr_en && (lb_req.addr == `HTX_STAT_ADDR) && lb_req.wr_data[0];

  // Control state and bus valids
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_en <= 1'b0;
      drvr_en  <= 1'b0;
      undrflw  <= 1'b0;
      wr_valid <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      if (cfg_wr)
      begin
        fetch_en <= lb_req.wr_data[0];
        drvr_en  <= lb_req.wr_data[1];
      end
      // A new event beats a clear in the same cycle
      if (undrflw_evt)
        undrflw <= 1'b1;
      else if (stat_clr)
        undrflw <= 1'b0;
      wr_valid <= lb_req.wr_en;
      rd_valid <= lb_req.rd_en;
    end
  end

  // Read mux, samples register values at the strobe edge
  always_ff @(posedge clk)
  begin
    if (lb_req.rd_en)
    begin
      case (lb_req.addr)
        `HTX_CFG_ADDR:  rd_data <= {{(`HTX_LB_DATA_W-2){1'b0}}, drvr_en, fetch_en};
        `HTX_STAT_ADDR: rd_data <= {{(`HTX_LB_DATA_W-1){1'b0}}, undrflw};
        `HTX_OCC_ADDR:  rd_data <= {{(`HTX_LB_DATA_W-`HTX_OCC_W){1'b0}}, occ};
        default:        rd_data <= `HTX_DEFAULT_RD;
      endcase
    end
  end

  assign lb_rsp.wr_valid = wr_valid;
  assign lb_rsp.rd_valid = rd_valid;
  assign lb_rsp.rd_data  = rd_data;

  assign ctrl.fetch_en   = fetch_en;
  assign ctrl.drvr_en    = drvr_en;

endmodule

/* logic/hdmi_tx_pkg.sv */
////////////////////////////////////////
// Bundled signal types for the HDMI TX path
// Used by every RTL block and the testbench
////////////////////////////////////////

`include "hdmi_tx_macros.svh"

package hdmi_tx_pkg;

  // Local bus request from the host
  typedef struct packed {
    logic                        wr_en;
    logic                        rd_en;
    logic [`HTX_LB_ADDR_W-1:0]   addr;
    logic [`HTX_LB_DATA_W-1:0]   wr_data;
  } lb_req_t;

  // Local bus response, both valids one cycle after strobe
  typedef struct packed {
    logic                        wr_valid;
    logic                        rd_valid;
    logic [`HTX_LB_DATA_W-1:0]   rd_data;
  } lb_rsp_t;

  // Read-only request toward system memory
  typedef struct packed {
    logic                        rd_en;
    logic [`HTX_MEM_ADDR_W-1:0]  addr;
  } mem_req_t;

  // Memory reply
  // wait_lvl stalls the request, rd_valid is a per-word pulse
  typedef struct packed {
    logic                        wait_lvl;
    logic                        rd_valid;
    logic [`HTX_MEM_DATA_W-1:0]  rd_data;
  } mem_rsp_t;

  // Configuration bits
  typedef struct packed {
    logic                        fetch_en;
    logic                        drvr_en;
  } ctrl_t;

  // Raster position flags, logical levels
  typedef struct packed {
    logic                        active;
    logic                        hsync;
    logic                        vsync;
  } raster_t;

  // Transmitter pins, sync active low
  typedef struct packed {
    logic [`HTX_PIX_W-1:0]       d;
    logic                        de;
    logic                        hs;
    logic                        vs;
  } hdmi_out_t;

endpackage

/* logic/hdmi_tx_macros.svh */
////////////////////////////////////////
// Shared sizes for the HDMI TX controller
// Raster, frame buffer, line buffer, bus widths
// Include wherever a width or address is needed
////////////////////////////////////////

`ifndef HDMI_TX_MACROS_SVH
`define HDMI_TX_MACROS_SVH

// Local bus and system memory widths
`define HTX_LB_ADDR_W   8
`define HTX_LB_DATA_W   32
`define HTX_MEM_ADDR_W  27
`define HTX_MEM_DATA_W  32
`define HTX_PIX_W       24

// Horizontal timing in pixels
`define HTX_H_ACTIVE    16
`define HTX_H_FP        2
`define HTX_H_SYNC      3
`define HTX_H_BP        3

// Vertical timing in lines
`define HTX_V_ACTIVE    4
`define HTX_V_FP        1
`define HTX_V_SYNC      2
`define HTX_V_BP        1

// Frame buffer placement in word addresses
`define HTX_FB_BASE     256
`define HTX_FB_WORDS    (`HTX_H_ACTIVE * `HTX_V_ACTIVE)

// Line buffer, count wide enough to hold the full depth
`define HTX_BUF_DEPTH   32
`define HTX_OCC_W       6

// Register map
`define HTX_CFG_ADDR    8'h00
`define HTX_STAT_ADDR   8'h01
`define HTX_OCC_ADDR    8'h02
`define HTX_DEFAULT_RD  32'hdeadbabe

`endif
